// File: hw/st_path_pkg.sv
/*
 * shared sizes, transfer size encoding and store request and entry types
 */
package st_path_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // address width, physical equals virtual here
    localparam int unsigned ADDR_W = 32;
    // one data word of the memory port
    localparam int unsigned DATA_W = 64;
    // one byte enable per byte of the data word
    localparam int unsigned BE_W   = DATA_W / 8;
    // transaction id carried along with every store
    localparam int unsigned TID_W  = 4;

    // ------------------------------
    // transfer size
    // ------------------------------
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'b00,
        SZ_HALF  = 2'b01,
        SZ_WORD  = 2'b10,
        SZ_DWORD = 2'b11
    } st_size_e;

    // ------------------------------
    // request and entry types
    // ------------------------------
    // incoming store, data unaligned in the low bytes (102 bits)
    typedef struct packed {
        logic [ADDR_W-1:0] vaddr;
        logic [DATA_W-1:0] data;
        st_size_e          size;
        logic [TID_W-1:0]  trans_id;
    } st_req_t;

    // buffered store, data already shifted into its byte lane (110 bits)
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be;
        st_size_e          size;
        logic [TID_W-1:0]  trans_id;
    } st_entry_t;

endpackage

// File: hw/store_unit.sv
`timescale 1ns/1ps
/*
 * store unit: four-phase request handshake, data re-aligner and byte enables
 */
module store_unit import st_path_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // issue side, four-phase req/ack
    input  logic      st_req_i,
    input  st_req_t   st_req_data_i,
    output logic      st_ack_o,
    // towards the store buffer
    input  logic      push_ready_i,
    output logic      push_o,
    output st_entry_t push_entry_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_ACK
    } state_e;

    state_e          state_q, state_d;
    st_entry_t       entry_d, entry_q;
    // byte offset inside the 64-bit word
    logic [2:0]      byte_off;
    // byte enables before shifting into the lane
    logic [BE_W-1:0] be_base;

    // ------------------------------
    // re-aligner
    // ------------------------------
    assign byte_off = st_req_data_i.vaddr[2:0];

    always_comb begin
        // run of ones given by the transfer size
        case (st_req_data_i.size)
            SZ_BYTE:  be_base = 8'b0000_0001;
            SZ_HALF:  be_base = 8'b0000_0011;
            SZ_WORD:  be_base = 8'b0000_1111;
            default:  be_base = 8'b1111_1111;
        endcase
    end

    always_comb begin
        // no translation, physical address is the virtual one
        entry_d.paddr    = st_req_data_i.vaddr;
        // shift by eight times the byte offset
        // bytes pushed past the top of the word are lost
        entry_d.data     = st_req_data_i.data << {byte_off, 3'b000};
        entry_d.be       = be_base << byte_off;
        entry_d.size     = st_req_data_i.size;
        entry_d.trans_id = st_req_data_i.trans_id;
    end

    // ------------------------------
    // handshake FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        push_o  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // entry gets registered on the same edge
                if (st_req_i) begin
                    state_d = ST_PUSH;
                end
            end
            ST_PUSH: begin
                // a flush drops the store, still acknowledge it
                if (flush_i) begin
                    state_d = ST_ACK;
                end else if (push_ready_i) begin
                    push_o  = 1'b1;
                    state_d = ST_ACK;
                end
            end
            ST_ACK: begin
                // wait for the requester to release
                if (!st_req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ack stays up for the whole ACK state
    assign st_ack_o     = (state_q == ST_ACK);
    assign push_entry_o = entry_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload capture when a new request is accepted
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && st_req_i) begin
            entry_q <= entry_d;
        end
    end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/1ps
/*
 * store buffer: speculative and committed circular queues,
 * commit, flush and page offset matching against a load
 */
module store_buffer import st_path_pkg::*; #(
    parameter int unsigned DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    // from the store unit
    input  logic        push_i,
    input  st_entry_t   push_entry_i,
    output logic        push_ready_o,
    // in-order commit
    input  logic        commit_i,
    output logic        commit_ready_o,
    // committed head towards the memory writer
    output logic        cq_valid_o,
    output st_entry_t   cq_head_o,
    input  logic        cq_pop_i,
    output logic        buf_empty_o,
    // load address check
    input  logic [11:0] page_offset_i,
    output logic        page_offset_matches_o
);

    // DEPTH is a power of two so the pointers wrap by themselves
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    // speculative queue
    st_entry_t        sq_mem [DEPTH];
    logic [PTR_W-1:0] sq_rptr_q, sq_wptr_q;
    logic [CNT_W-1:0] sq_cnt_q;
    // committed queue
    st_entry_t        cq_mem [DEPTH];
    logic [PTR_W-1:0] cq_rptr_q, cq_wptr_q;
    logic [CNT_W-1:0] cq_cnt_q;

    logic             do_push, do_commit, do_pop;
    logic [DEPTH-1:0] sq_hit, cq_hit;

    // ------------------------------
    // status
    // ------------------------------
    assign push_ready_o   = (sq_cnt_q != CNT_W'(DEPTH));
    assign commit_ready_o = (sq_cnt_q != '0) && (cq_cnt_q != CNT_W'(DEPTH));
    assign cq_valid_o     = (cq_cnt_q != '0);
    assign cq_head_o      = cq_mem[cq_rptr_q];
    assign buf_empty_o    = (sq_cnt_q == '0) && (cq_cnt_q == '0);

    assign do_push   = push_i & push_ready_o;
    assign do_commit = commit_i & commit_ready_o;
    assign do_pop    = cq_pop_i & cq_valid_o;

    // ------------------------------
    // speculative queue control
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sq_rptr_q <= '0;
            sq_wptr_q <= '0;
            sq_cnt_q  <= '0;
        end else if (flush_i) begin
            // everything not yet committed is gone
            sq_rptr_q <= '0;
            sq_wptr_q <= '0;
            sq_cnt_q  <= '0;
        end else begin
            if (do_push) begin
                sq_wptr_q <= sq_wptr_q + 1'b1;
            end
            if (do_commit) begin
                sq_rptr_q <= sq_rptr_q + 1'b1;
            end
            sq_cnt_q <= sq_cnt_q + CNT_W'(do_push) - CNT_W'(do_commit);
        end
    end

    // ------------------------------
    // committed queue control
    // ------------------------------
    // a commit in the flush cycle still lands here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cq_rptr_q <= '0;
            cq_wptr_q <= '0;
            cq_cnt_q  <= '0;
        end else begin
            if (do_commit) begin
                cq_wptr_q <= cq_wptr_q + 1'b1;
            end
            if (do_pop) begin
                cq_rptr_q <= cq_rptr_q + 1'b1;
            end
            cq_cnt_q <= cq_cnt_q + CNT_W'(do_commit) - CNT_W'(do_pop);
        end
    end

    // storage, the commit copies the speculative head to the committed tail
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            sq_mem[sq_wptr_q] <= push_entry_i;
        end
        if (do_commit) begin
            cq_mem[cq_wptr_q] <= sq_mem[sq_rptr_q];
        end
    end

    // ------------------------------
    // page offset match
    // ------------------------------
    // slot is live when its distance from the read pointer is below the count
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        logic [PTR_W-1:0] sq_rel, cq_rel;
        assign sq_rel    = PTR_W'(i) - sq_rptr_q;
        assign cq_rel    = PTR_W'(i) - cq_rptr_q;
        // word granularity, bits 11 to 3
        assign sq_hit[i] = ({1'b0, sq_rel} < sq_cnt_q)
                           && (sq_mem[i].paddr[11:3] == page_offset_i[11:3]);
        assign cq_hit[i] = ({1'b0, cq_rel} < cq_cnt_q)
                           && (cq_mem[i].paddr[11:3] == page_offset_i[11:3]);
    end

    assign page_offset_matches_o = (|sq_hit) | (|cq_hit);

endmodule

// File: hw/mem_writer.sv
`timescale 1ns/1ps
/*
 * memory writer: drains committed stores over a four-phase req/ack port
 */
module mem_writer import st_path_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // committed queue head
    input  logic      cq_valid_i,
    input  st_entry_t cq_head_i,
    output logic      cq_pop_o,
    input  logic      buf_empty_i,
    // memory port
    output logic      mem_req_o,
    output st_entry_t mem_o,
    input  logic      mem_ack_i,
    output logic      no_st_pending_o
);

    typedef enum logic [1:0] {
        MW_IDLE,
        MW_REQ,
        MW_RELEASE
    } state_e;

    state_e state_q, state_d;
    logic   load_head;

    // start a transfer whenever a committed store waits
    assign load_head = (state_q == MW_IDLE) && cq_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MW_IDLE: begin
                if (cq_valid_i) begin
                    state_d = MW_REQ;
                end
            end
            // memory has written once ack rises
            MW_REQ: begin
                if (mem_ack_i) begin
                    state_d = MW_RELEASE;
                end
            end
            MW_RELEASE: begin
                if (!mem_ack_i) begin
                    state_d = MW_IDLE;
                end
            end
            default: begin
                state_d = MW_IDLE;
            end
        endcase
    end

    assign mem_req_o       = (state_q == MW_REQ);
    // entry leaves the queue in the cycle ack is seen low
    assign cq_pop_o        = (state_q == MW_RELEASE) && !mem_ack_i;
    assign no_st_pending_o = (state_q == MW_IDLE) && buf_empty_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // hold the store stable while it is in flight
    always_ff @(posedge clk_i) begin
        if (load_head) begin
            mem_o <= cq_head_i;
        end
    end

endmodule

// File: hw/st_path_top.sv
`timescale 1ns/1ps
/*
 * store path top: store unit, store buffer and memory writer
 */
module st_path_top import st_path_pkg::*; #(
    parameter int unsigned DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    // issue side
    input  logic        st_req_i,
    input  st_req_t     st_req_data_i,
    output logic        st_ack_o,
    // commit and load check
    input  logic        commit_i,
    output logic        commit_ready_o,
    input  logic [11:0] page_offset_i,
    output logic        page_offset_matches_o,
    output logic        no_st_pending_o,
    // memory port
    output logic        mem_req_o,
    output st_entry_t   mem_o,
    input  logic        mem_ack_i
);

    // ------------------------------
    // internal links
    // ------------------------------
    logic      push, push_ready;
    st_entry_t push_entry;
    logic      cq_valid, cq_pop, buf_empty;
    st_entry_t cq_head;

    store_unit u_store_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .st_req_i      (st_req_i),
        .st_req_data_i (st_req_data_i),
        .st_ack_o      (st_ack_o),
        .push_ready_i  (push_ready),
        .push_o        (push),
        .push_entry_o  (push_entry)
    );

    store_buffer #(
        .DEPTH (DEPTH)
    ) u_store_buffer (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .push_i                (push),
        .push_entry_i          (push_entry),
        .push_ready_o          (push_ready),
        .commit_i              (commit_i),
        .commit_ready_o        (commit_ready_o),
        .cq_valid_o            (cq_valid),
        .cq_head_o             (cq_head),
        .cq_pop_i              (cq_pop),
        .buf_empty_o           (buf_empty),
        .page_offset_i         (page_offset_i),
        .page_offset_matches_o (page_offset_matches_o)
    );

    mem_writer u_mem_writer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cq_valid_i      (cq_valid),
        .cq_head_i       (cq_head),
        .cq_pop_o        (cq_pop),
        .buf_empty_i     (buf_empty),
        .mem_req_o       (mem_req_o),
        .mem_o           (mem_o),
        .mem_ack_i       (mem_ack_i),
        .no_st_pending_o (no_st_pending_o)
    );

endmodule

// File: test/st_path_assertions.sv
`timescale 1ns/1ps
/*
 * handshake and queue assertions for the store path, bound to the top level
 */
module st_path_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic st_req_i,
    input logic st_ack_i,
    input logic push_i,
    input logic push_ready_i,
    input logic commit_i,
    input logic commit_ready_i,
    input logic mem_req_i,
    input logic mem_ack_i
);

    // ------------------------------
    // handshakes
    // ------------------------------
    // request to memory holds until the memory answers
    a_mem_req_hold : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_i && !mem_ack_i) |=> mem_req_i
    ) else $error("mem_req_o fell before mem_ack_i rose");

    // idle unit with no request never acknowledges
    a_ack_idle : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (!st_req_i && !st_ack_i) |=> !st_ack_i
    ) else $error("st_ack_o rose without a request");

    // ------------------------------
    // queues
    // ------------------------------
    a_push_ready : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_i |-> push_ready_i
    ) else $error("push while the speculative queue is full");

    a_commit_ready : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        commit_i |-> commit_ready_i
    ) else $error("commit while commit_ready_o is low");

endmodule

// File: test/st_path_tb.sv
`timescale 1ns/1ps
/*
 * store path testbench with clock, reset, file driven stimulus,
 * memory model with random ack delay and result checks
 */
module st_path_tb import st_path_pkg::*; ();

    localparam int unsigned DEPTH = 4;
    // longest any single wait may take
    localparam int TIMEOUT_CYCLES = 500;
    // cycles a store into a full buffer must stay unacknowledged
    localparam int STALL_CYCLES = 6;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        st_req;
    st_req_t     st_req_data;
    logic        st_ack;
    logic        commit;
    logic        commit_ready;
    logic [11:0] page_offset;
    logic        page_match;
    logic        no_st_pending;
    logic        mem_req;
    st_entry_t   mem_entry;
    logic        mem_ack;

    // memory model words keyed by word aligned address
    logic [63:0] mem [logic [31:0]];
    integer      seed = 32'hb620;
    logic [3:0]  tid;
    // ids of acknowledged stores that are not committed yet, oldest first
    logic [3:0]  spec_tids [$];
    // ids of committed stores in the order memory must see them
    logic [3:0]  commit_tids [$];

    always #5 clk = ~clk;

    st_path_top #(
        .DEPTH (DEPTH)
    ) u_st_path_top (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .flush_i               (flush),
        .st_req_i              (st_req),
        .st_req_data_i         (st_req_data),
        .st_ack_o              (st_ack),
        .commit_i              (commit),
        .commit_ready_o        (commit_ready),
        .page_offset_i         (page_offset),
        .page_offset_matches_o (page_match),
        .no_st_pending_o       (no_st_pending),
        .mem_req_o             (mem_req),
        .mem_o                 (mem_entry),
        .mem_ack_i             (mem_ack)
    );

    bind st_path_top st_path_assertions u_st_path_assertions (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .st_req_i       (st_req_i),
        .st_ack_i       (st_ack_o),
        .push_i         (push),
        .push_ready_i   (push_ready),
        .commit_i       (commit_i),
        .commit_ready_i (commit_ready_o),
        .mem_req_i      (mem_req_o),
        .mem_ack_i      (mem_ack_i)
    );

    // ------------------------------
    // failure reporting
    // ------------------------------
    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t after %0d cycles: %s", $time, TIMEOUT_CYCLES, what);
        abort_run();
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed line in the stimulus file");
            abort_run();
        end
    endtask

    // ------------------------------
    // bounded waits
    // ------------------------------
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (st_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("st_ack_o never reached the expected level");
            end
        end
    endtask

    task automatic wait_commit_ready();
        int cycles;
        cycles = 0;
        while (commit_ready !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("commit_ready_o never went high");
            end
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (no_st_pending !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("stores were still pending");
            end
        end
    endtask

    // ------------------------------
    // memory model
    // ------------------------------
    function automatic logic [63:0] read_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:3], 3'b000};
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        // untouched words hold their own address twice
        return {waddr, waddr};
    endfunction

    task automatic write_word(input st_entry_t e);
        logic [31:0] waddr;
        logic [63:0] word;
        waddr = {e.paddr[31:3], 3'b000};
        word  = read_word(waddr);
        for (int i = 0; i < 8; i++) begin
            if (e.be[i]) begin
                word[8*i +: 8] = e.data[8*i +: 8];
            end
        end
        mem[waddr] = word;
    endtask

    // four-phase responder with a random delay on both edges of ack
    initial begin : memory_model
        int unsigned delay;
        mem_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_req && !mem_ack) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                // writes arrive in commit order
                if (commit_tids.size() == 0) begin
                    $display("memory write at %0t with no committed store left", $time);
                    abort_run();
                end else begin
                    check_equal(64'(mem_entry.trans_id), 64'(commit_tids.pop_front()),
                                "store order at the memory port");
                end
                write_word(mem_entry);
                mem_ack = 1'b1;
            end else if (!mem_req && mem_ack) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic commit_store();
        wait_commit_ready();
        // oldest speculative store moves over to the committed side
        if (spec_tids.size() != 0) begin
            commit_tids.push_back(spec_tids.pop_front());
        end
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
    endtask

    // blocked stores expect a full speculative queue and free a slot themselves
    task automatic issue_store(input logic [31:0] addr, input logic [63:0] data,
                               input int size, input bit blocked);
        int cycles;
        st_req_data.vaddr    = addr;
        st_req_data.data     = data;
        st_req_data.size     = st_size_e'(size[1:0]);
        st_req_data.trans_id = tid;
        tid    = tid + 4'd1;
        st_req = 1'b1;
        if (blocked) begin
            repeat (STALL_CYCLES) begin
                @(negedge clk);
                check_equal(64'(st_ack), 64'd0, "st_ack_o with a full buffer");
            end
            commit_store();
        end
        wait_ack(1'b1, cycles);
        if (!blocked) begin
            // two cycles after the edge that samples the request
            check_equal(64'(cycles), 64'd2, "store ack latency");
        end
        spec_tids.push_back(st_req_data.trans_id);
        st_req = 1'b0;
        wait_ack(1'b0, cycles);
    endtask

    task automatic flush_stores();
        flush = 1'b1;
        spec_tids.delete();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic query_offset(input logic [31:0] off, input int exp);
        page_offset = off[11:0];
        @(negedge clk);
        check_equal(64'(page_match), 64'(exp), "page offset match");
    endtask

    initial begin : stimulus
        int          fd;
        int          code;
        int          ch;
        int          val;
        logic [7:0]  cmd;
        logic [31:0] addr;
        logic [63:0] data;
        bit          done;

        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        st_req      = 1'b0;
        st_req_data = '0;
        commit      = 1'b0;
        page_offset = '0;
        tid         = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // state right after reset
        check_equal(64'(st_ack), 64'd0, "st_ack_o after reset");
        check_equal(64'(mem_req), 64'd0, "mem_req_o after reset");
        check_equal(64'(commit_ready), 64'd0, "commit_ready_o after reset");
        check_equal(64'(page_match), 64'd0, "page_offset_matches_o after reset");
        check_equal(64'(no_st_pending), 64'd1, "no_st_pending_o after reset");

        fd = $fopen("test/st_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/st_stim.txt");
            abort_run();
        end

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        // comment runs to the end of the line
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end
                    "S", "B": begin
                        code = $fscanf(fd, "%h %h %d", addr, data, val);
                        check_fields(code, 3);
                        issue_store(addr, data, val, cmd == "B");
                    end
                    "C": commit_store();
                    "F": flush_stores();
                    "D": wait_drained();
                    "P": begin
                        code = $fscanf(fd, "%h %d", addr, val);
                        check_fields(code, 2);
                        query_offset(addr, val);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        check_fields(code, 2);
                        check_equal(read_word(addr), data, "memory word");
                    end
                    default: begin
                        $display("unknown command %c in the stimulus file", cmd);
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);

        // every committed store has reached memory
        check_equal(64'(commit_tids.size()), 64'd0, "committed stores left unwritten");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: st_path.f
hw/st_path_pkg.sv
hw/store_unit.sv
hw/store_buffer.sv
hw/mem_writer.sv
hw/st_path_top.sv
test/st_path_assertions.sv
test/st_path_tb.sv

// File: Makefile
# Verilator build of the store path testbench

VERILATOR ?= verilator
TOP       ?= st_path_tb
FILELIST  ?= st_path.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/st_stim.txt
# S/B addr data size (0 byte, 1 half, 2 word, 3 dword), B must wait for a commit
# C commit, F flush, D drain, P offset expected_match, M word_addr expected_word
S 00000103 ab 0
S 0000010a 1234 1
S 00000114 cafef00d 2
S 00000118 0123456789abcdef 3
C
C
C
C
D
M 00000100 00000100ab000100
M 00000108 0000010812340108
M 00000110 cafef00d00000110
M 00000118 0123456789abcdef
S 00000200 1111 1
S 00000200 2222 1
P 200 1
P 208 0
C
C
D
M 00000200 0000020000002222
P 200 0
S 00000300 aa 0
C
S 00000308 bb 0
F
D
M 00000300 00000300000003aa
M 00000308 0000030800000308
S 00000400 01 0
S 00000401 02 0
S 00000402 03 0
S 00000403 04 0
B 00000404 05 0
C
C
C
C
D
M 00000400 0000040504030201
